/* src/axi_mem_pkg.sv */
`default_nettype none

package axi_mem_pkg;

  ////////////////////////////////////////
  // widths and depth
  ////////////////////////////////////////

  // one AXI data word
  localparam int data_w = 32;
  // one strobe bit per byte lane
  localparam int strb_w = data_w / 8;
  // AXI byte address
  localparam int addr_w = 32;

  // on-chip memory size in words
  localparam int mem_depth = 1024;
  localparam int word_addr_w = $clog2(mem_depth);

  // byte offset bits below the word index
  localparam int byte_off_w = $clog2(strb_w);

  ////////////////////////////////////////
  // burst codes
  ////////////////////////////////////////

  // WRAP (2'b10) is not supported
  localparam logic [1:0] burst_fixed = 2'd0;
  localparam logic [1:0] burst_incr  = 2'd1;

  ////////////////////////////////////////
  // channel payloads
  ////////////////////////////////////////

  // read request as held in the AR buffer
  typedef struct packed {
    logic [addr_w-1:0] addr;
    logic [7:0]        len;
    logic [1:0]        burst;
  } ar_payload_t;

  // one read beat as held in the R buffer
  typedef struct packed {
    logic [data_w-1:0] data;
    logic              last;
  } r_payload_t;

endpackage

`default_nettype wire

/* src/axi_chan_reg.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_chan_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  // upstream side
  input  logic     in_valid,
  output logic     in_ready,
  input  payload_t in_data,
  // downstream side
  output logic     out_valid,
  input  logic     out_ready,
  output payload_t out_data
);

  // main entry drives the output, skid entry catches the overflow
  logic     main_v;
  logic     skid_v;
  payload_t main_q;
  payload_t skid_q;
  logic     push;
  logic     pop;

  // ready comes from a flop only, so no comb path to out_ready
  assign in_ready  = !skid_v;
  assign out_valid = main_v;
  assign out_data  = main_q;

  assign push = in_valid && in_ready;
  assign pop  = main_v && out_ready;

  // occupancy
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      main_v <= 1'b0;
      skid_v <= 1'b0;
    end else if (!main_v || pop) begin
      // main slot frees up, refill from skid first
      if (skid_v) begin
        main_v <= 1'b1;
        skid_v <= 1'b0;
      end else begin
        main_v <= push;
      end
    end else if (push) begin
      // output stalled, park in skid
      skid_v <= 1'b1;
    end
  end

  // payload path, same decisions as above
  always_ff @(posedge clk) begin
    if (!main_v || pop) begin
      if (skid_v) begin
        main_q <= skid_q;
      end else if (push) begin
        main_q <= in_data;
      end
    end else if (push) begin
      skid_q <= in_data;
    end
  end

endmodule

`default_nettype wire

/* src/axi_write_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_write_ctrl import axi_mem_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // write address
  input  logic                   awvalid,
  output logic                   awready,
  input  logic [addr_w-1:0]      awaddr,
  // write data, always one beat
  input  logic                   wvalid,
  output logic                   wready,
  input  logic [data_w-1:0]      wdata,
  input  logic [strb_w-1:0]      wstrb,
  // write response
  output logic                   bvalid,
  input  logic                   bready,
  // memory write port
  output logic                   mem_we,
  output logic [word_addr_w-1:0] mem_waddr,
  output logic [data_w-1:0]      mem_wdata,
  output logic [strb_w-1:0]      mem_wbe
);

  ////////////////////////////////////////
  // write acceptance
  ////////////////////////////////////////

  // response still owed to the master
  logic b_pend;
  // aw and w handshake together on this edge
  logic accept;

  // both channels must be present, and no response waiting
  assign accept = awvalid && wvalid && !b_pend;

  // one shared ready, so aw and w always complete together
  assign awready = accept;
  assign wready  = accept;

  ////////////////////////////////////////
  // memory write port
  ////////////////////////////////////////

  // memory is written on the handshake edge itself
  assign mem_we = accept;

  // drop byte offset, upper bits beyond depth ignored
  assign mem_waddr = awaddr[byte_off_w +: word_addr_w];

  // data and strobes go straight through to the array
  assign mem_wdata = wdata;
  assign mem_wbe   = wstrb;

  ////////////////////////////////////////
  // write response
  ////////////////////////////////////////

  // set on accept, so bvalid shows one cycle later
  // cleared when the master takes it
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      b_pend <= 1'b0;
    end else if (accept) begin
      b_pend <= 1'b1;
    end else if (bready) begin
      // only reached while b_pend is high or already low
      b_pend <= 1'b0;
    end
  end

  // response is always OKAY, so only the valid leaves
  assign bvalid = b_pend;

endmodule

`default_nettype wire

/* src/axi_read_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_read_ctrl import axi_mem_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // request from the AR buffer
  input  logic                   req_valid,
  output logic                   req_ready,
  input  ar_payload_t            req,
  // memory read port
  output logic                   mem_re,
  output logic [word_addr_w-1:0] mem_raddr,
  // beat entering the R buffer, one cycle after mem_re
  output logic                   beat_valid,
  output logic                   beat_last,
  // R handshake at the top, frees one credit
  input  logic                   beat_taken
);

  // burst in progress
  logic                   active;
  // current beat address as a word index
  logic [word_addr_w-1:0] addr_q;
  logic [word_addr_w-1:0] addr_next;
  // beats left after the current one
  logic [7:0]             left_q;
  logic [1:0]             burst_q;
  // beats in memory stage plus beats held in R buffer
  logic [1:0]             credit_q;
  logic                   issue;
  logic                   issue_last;
  logic                   load;

  ////////////////////////////////////////
  // issue and load decisions
  ////////////////////////////////////////

  // at most two beats past the issue point
  assign issue      = active && (credit_q < 2'd2);
  assign issue_last = issue && (left_q == 8'd0);

  // next request may load on the edge of the final issue
  assign req_ready = !active || issue_last;
  assign load      = req_valid && req_ready;

  assign mem_re    = issue;
  assign mem_raddr = addr_q;

  // next beat address
  always_comb begin
    case (burst_q)
      burst_fixed: addr_next = addr_q;
      // word index rolls over at mem_depth on its own
      burst_incr:  addr_next = addr_q + 1'b1;
      // wrap and reserved codes repeat the word
      default:     addr_next = addr_q;
    endcase
  end

  ////////////////////////////////////////
  // control state
  ////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      active     <= 1'b0;
      credit_q   <= 2'd0;
      beat_valid <= 1'b0;
      beat_last  <= 1'b0;
    end else begin
      if (load) begin
        active <= 1'b1;
      end else if (issue_last) begin
        active <= 1'b0;
      end
      // issue takes a credit, an R handshake returns one
      credit_q <= credit_q + {1'b0, issue} - {1'b0, beat_taken};
      // line up with the registered memory read
      beat_valid <= issue;
      beat_last  <= issue_last;
    end
  end

  ////////////////////////////////////////
  // burst walker
  ////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (load) begin
      // byte offset dropped, size is always a full word
      addr_q  <= req.addr[byte_off_w +: word_addr_w];
      left_q  <= req.len;
      burst_q <= req.burst;
    end else if (issue) begin
      addr_q <= addr_next;
      left_q <= left_q - 8'd1;
    end
  end

endmodule

`default_nettype wire

/* src/mem_array.sv */
`timescale 1ns/1ps
`default_nettype none

module mem_array import axi_mem_pkg::*; (
  input  logic                   clk,
  // write port
  input  logic                   we,
  input  logic [word_addr_w-1:0] waddr,
  input  logic [data_w-1:0]      wdata,
  input  logic [strb_w-1:0]      wbe,
  // read port, data one cycle after re
  input  logic                   re,
  input  logic [word_addr_w-1:0] raddr,
  output logic [data_w-1:0]      rdata
);

  // word storage
  logic [data_w-1:0] mem [mem_depth];

  // byte lane writes
  always_ff @(posedge clk) begin
    if (we) begin
      for (int b = 0; b < strb_w; b++) begin
        if (wbe[b]) begin
          mem[waddr][b*8 +: 8] <= wdata[b*8 +: 8];
        end
      end
    end
  end

  // registered read
  // same-word read and write on one edge returns old data
  always_ff @(posedge clk) begin
    if (re) begin
      rdata <= mem[raddr];
    end
  end

endmodule

`default_nettype wire

/* src/axi_mem_top.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_top import axi_mem_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  // write address
  input  logic              awvalid,
  output logic              awready,
  input  logic [addr_w-1:0] awaddr,
  // write data
  input  logic              wvalid,
  output logic              wready,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  // write response
  output logic              bvalid,
  input  logic              bready,
  // read address
  input  logic              arvalid,
  output logic              arready,
  input  logic [addr_w-1:0] araddr,
  input  logic [7:0]        arlen,
  input  logic [1:0]        arburst,
  // read data
  output logic              rvalid,
  output logic [data_w-1:0] rdata,
  output logic              rlast,
  input  logic              rready
);

  // AR buffer to read controller
  ar_payload_t            ar_in;
  ar_payload_t            ar_out;
  logic                   ar_out_valid;
  logic                   ar_out_ready;

  // memory ports
  logic                   mem_we;
  logic [word_addr_w-1:0] mem_waddr;
  logic [data_w-1:0]      mem_wdata;
  logic [strb_w-1:0]      mem_wbe;
  logic                   mem_re;
  logic [word_addr_w-1:0] mem_raddr;
  logic [data_w-1:0]      mem_rdata;

  // read beats into the R buffer
  logic                   beat_valid;
  logic                   beat_last;
  logic                   beat_taken;
  r_payload_t             r_in;
  r_payload_t             r_out;

  ////////////////////////////////////////
  // read path
  ////////////////////////////////////////

  assign ar_in = '{addr: araddr, len: arlen, burst: arburst};

  axi_chan_reg #(.payload_t(ar_payload_t)) ar_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (arvalid),
    .in_ready  (arready),
    .in_data   (ar_in),
    .out_valid (ar_out_valid),
    .out_ready (ar_out_ready),
    .out_data  (ar_out)
  );

  // R handshake returns a credit
  assign beat_taken = rvalid && rready;

  axi_read_ctrl axi_read_ctrl_inst (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_valid  (ar_out_valid),
    .req_ready  (ar_out_ready),
    .req        (ar_out),
    .mem_re     (mem_re),
    .mem_raddr  (mem_raddr),
    .beat_valid (beat_valid),
    .beat_last  (beat_last),
    .beat_taken (beat_taken)
  );

  // memory word joins its delayed last flag
  assign r_in = '{data: mem_rdata, last: beat_last};

  // credits keep this buffer from overflowing, so in_ready goes unused
  axi_chan_reg #(.payload_t(r_payload_t)) r_buf (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (beat_valid),
    .in_ready  (),
    .in_data   (r_in),
    .out_valid (rvalid),
    .out_ready (rready),
    .out_data  (r_out)
  );

  assign rdata = r_out.data;
  assign rlast = r_out.last;

  ////////////////////////////////////////
  // write path and storage
  ////////////////////////////////////////

  axi_write_ctrl axi_write_ctrl_inst (
    .clk       (clk),
    .rst_n     (rst_n),
    .awvalid   (awvalid),
    .awready   (awready),
    .awaddr    (awaddr),
    .wvalid    (wvalid),
    .wready    (wready),
    .wdata     (wdata),
    .wstrb     (wstrb),
    .bvalid    (bvalid),
    .bready    (bready),
    .mem_we    (mem_we),
    .mem_waddr (mem_waddr),
    .mem_wdata (mem_wdata),
    .mem_wbe   (mem_wbe)
  );

  mem_array mem_array_inst (
    .clk   (clk),
    .we    (mem_we),
    .waddr (mem_waddr),
    .wdata (mem_wdata),
    .wbe   (mem_wbe),
    .re    (mem_re),
    .raddr (mem_raddr),
    .rdata (mem_rdata)
  );

endmodule

`default_nettype wire

/* tb/axi_mem_props.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_mem_props import axi_mem_pkg::*; (
  input logic              clk,
  input logic              rst_n,
  input logic              awready,
  input logic              wready,
  input logic              bvalid,
  input logic              bready,
  input logic              rvalid,
  input logic              rready,
  input logic              rlast,
  input logic [data_w-1:0] rdata
);

  // failed assertion count, read by the testbench top
  int fail_cnt = 0;

  // R beat held steady while stalled
  r_hold: assert property (@(posedge clk) disable iff (!rst_n)
    rvalid && !rready |=> rvalid && $stable(rdata) && $stable(rlast))
    else begin
      fail_cnt++;
      $error("r channel changed before rready");
    end

  // B response held until taken
  b_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid)
    else begin
      fail_cnt++;
      $error("bvalid dropped before bready");
    end

  // aw and w always complete together
  aw_w_ready: assert property (@(posedge clk) disable iff (!rst_n)
    awready == wready)
    else begin
      fail_cnt++;
      $error("awready and wready differ");
    end

endmodule

bind axi_mem_top axi_mem_props axi_mem_props_inst (
  .clk     (clk),
  .rst_n   (rst_n),
  .awready (awready),
  .wready  (wready),
  .bvalid  (bvalid),
  .bready  (bready),
  .rvalid  (rvalid),
  .rready  (rready),
  .rlast   (rlast),
  .rdata   (rdata)
);

`default_nettype wire

/* tb/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
  output logic clk,
  output logic rst_n
);

  // 40 ns period
  localparam int half_period = 20;
  localparam int rst_cycles  = 16;

  initial begin
    clk = 1'b0;
    forever #(half_period) clk = ~clk;
  end

  // released on a falling edge, away from the DUT clock edge
  initial begin
    rst_n = 1'b0;
    repeat (rst_cycles) @(negedge clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

/* tb/tb_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_checker import axi_mem_pkg::*; (
  input  logic              clk,
  input  logic              rst_n,
  input  logic              awvalid,
  input  logic              awready,
  input  logic [addr_w-1:0] awaddr,
  input  logic              wvalid,
  input  logic              wready,
  input  logic [data_w-1:0] wdata,
  input  logic [strb_w-1:0] wstrb,
  input  logic              bvalid,
  input  logic              bready,
  input  logic              arvalid,
  input  logic              arready,
  input  logic [addr_w-1:0] araddr,
  input  logic [7:0]        arlen,
  input  logic [1:0]        arburst,
  input  logic              rvalid,
  input  logic [data_w-1:0] rdata,
  input  logic              rlast,
  input  logic              rready,
  output int                tests_done,
  output int                tests_passed,
  output int                tests_failed,
  output int                check_errs
);

  // expected memory contents, x until written
  logic [data_w-1:0] shadow [mem_depth];
  // read requests not yet answered
  ar_payload_t       ar_q [$];
  ar_payload_t       cur;
  logic              cur_ok;
  int                beat = 0;
  int                writes_open = 0;
  int                n_done = 0;
  int                n_pass = 0;
  int                n_fail = 0;
  int                n_err = 0;

  assign tests_done   = n_done;
  assign tests_passed = n_pass;
  assign tests_failed = n_fail;
  assign check_errs   = n_err;

  task automatic finish_test(input string what, input logic ok);
    n_done++;
    if (ok) begin
      n_pass++;
    end else begin
      n_fail++;
    end
    $display("test %0d %s: %s", n_done, what, ok ? "pass" : "FAIL");
  endtask

  ////////////////////////////////////////
  // read beat comparison
  ////////////////////////////////////////

  task automatic check_beat();
    int unsigned       word;
    logic [data_w-1:0] exp;
    string             what;
    if (beat == 0) begin
      if (ar_q.size() == 0) begin
        $display("read beat arrived with no read request at %0t", $time);
        n_err++;
        return;
      end
      cur    = ar_q.pop_front();
      cur_ok = 1'b1;
    end
    // low bits and bits above the memory range drop out
    word = (cur.addr / strb_w) % mem_depth;
    if (cur.burst == burst_incr) begin
      word = (word + beat) % mem_depth;
    end
    exp = shadow[word];
    if (rdata !== exp) begin
      $display("ERR %0t: read %h beat %0d rdata %h expected %h",
               $time, cur.addr, beat, rdata, exp);
      cur_ok = 1'b0;
    end
    what = $sformatf("read %h len %0d burst %0d", cur.addr, cur.len, cur.burst);
    if (beat == cur.len) begin
      if (!rlast) begin
        $display("burst at %h ended after %0d beats without rlast", cur.addr, beat + 1);
        cur_ok = 1'b0;
      end
      finish_test(what, cur_ok);
      beat = 0;
    end else if (rlast) begin
      $display("rlast came after %0d beats, expected %0d beats", beat + 1, cur.len + 1);
      finish_test(what, 1'b0);
      beat = 0;
    end else begin
      beat++;
    end
  endtask

  ////////////////////////////////////////
  // channel monitors
  ////////////////////////////////////////

  always @(posedge clk) begin
    if (rst_n) begin
      if (awvalid && awready && wvalid && wready) begin
        for (int b = 0; b < strb_w; b++) begin
          if (wstrb[b]) begin
            shadow[(awaddr / strb_w) % mem_depth][b*8 +: 8] = wdata[b*8 +: 8];
          end
        end
        writes_open++;
      end
      // exactly one response per write
      if (bvalid && bready) begin
        if (writes_open == 0) begin
          $display("write response without a write at %0t", $time);
          n_err++;
        end else begin
          writes_open--;
          finish_test("write", 1'b1);
        end
      end
      if (arvalid && arready) begin
        ar_q.push_back('{addr: araddr, len: arlen, burst: arburst});
      end
      if (rvalid && rready) begin
        check_beat();
      end
    end
  end

endmodule

`default_nettype wire

/* tb/tb_axi_mem.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem import axi_mem_pkg::*; ;

  localparam logic [31:0] lcg_seed = 32'h2dc1cae6;

  // one table row, a write or a read burst
  typedef struct {
    logic        is_read;
    logic [31:0] addr;
    logic [7:0]  len;
    logic [1:0]  burst;
    logic [31:0] data;
    logic [3:0]  strb;
    logic        bp;
  } entry_t;

  entry_t              tbl [$];
  logic                clk;
  logic                rst_n;
  logic                awvalid;
  logic                awready;
  logic [addr_w-1:0]   awaddr;
  logic                wvalid;
  logic                wready;
  logic [data_w-1:0]   wdata;
  logic [strb_w-1:0]   wstrb;
  logic                bvalid;
  logic                bready;
  logic                arvalid;
  logic                arready;
  logic [addr_w-1:0]   araddr;
  logic [7:0]          arlen;
  logic [1:0]          arburst;
  logic                rvalid;
  logic [data_w-1:0]   rdata;
  logic                rlast;
  logic                rready;
  int                  tests_done;
  int                  tests_passed;
  int                  tests_failed;
  int                  check_errs;
  logic [31:0]         lcg_state = lcg_seed;
  int                  cycles = 0;
  int                  limit = 0;

  tb_clock_gen clock_gen_inst (.*);
  axi_mem_top axi_mem_top_inst (.*);
  tb_checker checker_inst (.*);

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // low bits of this generator have short periods, bit 16 does not
  function automatic logic next_rready(input logic bp);
    if (!bp) begin
      return 1'b1;
    end
    lcg_state = lcg_next(lcg_state);
    return lcg_state[16];
  endfunction

  // fill value mixes every address bit
  function automatic logic [31:0] fill_word(input int unsigned word);
    return (word * 32'h9e3779b1) ^ 32'h5a5aa5a5;
  endfunction

  function automatic void add_write(input logic [31:0] a, d, input logic [3:0] s);
    tbl.push_back('{is_read: 1'b0, addr: a, len: 8'd0, burst: burst_incr,
                    data: d, strb: s, bp: 1'b0});
  endfunction

  function automatic void add_read(input logic [31:0] a, input logic [7:0] l,
                                   input logic [1:0] b, input logic p);
    tbl.push_back('{is_read: 1'b1, addr: a, len: l, burst: b,
                    data: '0, strb: '0, bp: p});
  endfunction

  ////////////////////////////////////////
  // stimulus table
  ////////////////////////////////////////

  function automatic void build_table();
    // preload the low words and the top of memory
    for (int i = 0; i < 32; i++) begin
      add_write(i * 4, fill_word(i), 4'hf);
    end
    for (int i = mem_depth - 4; i < mem_depth; i++) begin
      add_write(i * 4, fill_word(i), 4'hf);
    end
    // full write and single read back
    add_write(32'h100, 32'hcafe0123, 4'hf);
    add_read(32'h100, 8'd0, burst_incr, 1'b0);
    // partial strobes, high address bits and byte offset ignored
    add_write(32'h104, 32'h11223344, 4'hf);
    add_write(32'h00010104, 32'haabbccdd, 4'b0101);
    add_read(32'h106, 8'd0, burst_incr, 1'b0);
    add_read(32'h20, 8'd7, burst_incr, 1'b0);
    add_read(32'h50, 8'd3, burst_fixed, 1'b0);
    // starts two words below the top and wraps
    add_read((mem_depth - 2) * 4, 8'd5, burst_incr, 1'b0);
    // long burst under back-pressure
    add_read(32'h0, 8'd31, burst_incr, 1'b1);
  endfunction

  ////////////////////////////////////////
  // drivers, inputs change on the falling edge
  ////////////////////////////////////////

  task automatic do_write(input entry_t e);
    @(negedge clk);
    awvalid = 1'b1;
    awaddr  = e.addr;
    wvalid  = 1'b1;
    wdata   = e.data;
    wstrb   = e.strb;
    bready  = 1'b1;
    #1;
    while (!(awready && wready)) begin
      @(negedge clk);
      #1;
    end
    // handshake on the rising edge in between
    @(negedge clk);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) begin
      @(negedge clk);
    end
    @(negedge clk);
    bready = 1'b0;
  endtask

  task automatic do_read(input entry_t e);
    logic done;
    done = 1'b0;
    @(negedge clk);
    arvalid = 1'b1;
    araddr  = e.addr;
    arlen   = e.len;
    arburst = e.burst;
    #1;
    while (!arready) begin
      @(negedge clk);
      #1;
    end
    @(negedge clk);
    arvalid = 1'b0;
    // collect beats up to the one with rlast
    while (!done) begin
      rready = next_rready(e.bp);
      #1;
      if (rvalid && rready && rlast) begin
        done = 1'b1;
      end
      @(negedge clk);
    end
    rready = 1'b0;
  endtask

  ////////////////////////////////////////
  // timeout and main sequence
  ////////////////////////////////////////

  always @(posedge clk) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("timeout, run did not finish within %0d cycles", limit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    int beats;
    logic ok;
    awvalid = 1'b0;
    awaddr  = '0;
    wvalid  = 1'b0;
    wdata   = '0;
    wstrb   = '0;
    bready  = 1'b0;
    arvalid = 1'b0;
    araddr  = '0;
    arlen   = '0;
    arburst = '0;
    rready  = 1'b0;
    build_table();
    beats = 0;
    foreach (tbl[i]) begin
      beats += tbl[i].is_read ? tbl[i].len + 1 : 1;
    end
    limit = 16 + 8 * beats + 200;
    wait (rst_n === 1'b1);
    foreach (tbl[i]) begin
      if (tbl[i].is_read) begin
        do_read(tbl[i]);
      end else begin
        do_write(tbl[i]);
      end
    end
    repeat (4) @(negedge clk);
    ok = (tests_failed == 0) && (check_errs == 0) && (tests_done == tbl.size())
         && (axi_mem_top_inst.axi_mem_props_inst.fail_cnt == 0);
    $display("tests %0d of %0d, passed %0d, failed %0d, other errors %0d, assertion fails %0d",
             tests_done, tbl.size(), tests_passed, tests_failed, check_errs,
             axi_mem_top_inst.axi_mem_props_inst.fail_cnt);
    if (ok) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
src/axi_mem_pkg.sv
src/axi_chan_reg.sv
src/axi_write_ctrl.sv
src/axi_read_ctrl.sv
src/mem_array.sv
src/axi_mem_top.sv
tb/axi_mem_props.sv
tb/tb_clock_gen.sv
tb/tb_checker.sv
tb/tb_axi_mem.sv
